// File: Makefile
# Verilator flow for the operator attenuation path
TOP = tb_eg_atten
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f project.f

run: build
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG)

lint:
	verilator --lint-only --timing --top-module $(TOP) -f project.f

clean:
	rm -rf obj_dir $(LOG)

// File: hw/eg_atten_top.sv
/*
  One operator attenuation path: LFO, envelope and limiter.
  att_valid pulses two cycles after each sample_tick; the consumer cannot stall it.
*/
`timescale 1ns/100ps

module eg_atten_top
  import eg_pkg::*;
#(
  parameter int LFO_PRESCALE = 4
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             sample_tick,
  input  logic             key_on,
  input  logic             key_off,
  input  eg_cfg_t          cfg,
  input  logic             lfo_en,
  input  logic [2:0]       lfo_rate,
  output logic [ATT_W-1:0] att_out,
  output logic             att_valid
);

  logic [LFO_W-1:0] lfo_mod;
  logic [ATT_W-1:0] eg_att;
  logic             ssg_inv;

  eg_lfo_am #(
    .LFO_PRESCALE (LFO_PRESCALE)
  ) u_lfo (
    .clk         (clk),
    .rst_n       (rst_n),
    .sample_tick (sample_tick),
    .lfo_en      (lfo_en),
    .lfo_rate    (lfo_rate),
    .lfo_mod     (lfo_mod)
  );

  eg_envelope u_env (
    .clk         (clk),
    .rst_n       (rst_n),
    .sample_tick (sample_tick),
    .key_on      (key_on),
    .key_off     (key_off),
    .cfg         (cfg),
    .eg_att      (eg_att),
    .ssg_inv     (ssg_inv)
  );

  // Limiter only looks at tl, amsen and ams
  eg_limiter u_lim (
    .clk         (clk),
    .rst_n       (rst_n),
    .sample_tick (sample_tick),
    .cfg         (cfg),
    .lfo_mod     (lfo_mod),
    .eg_att      (eg_att),
    .ssg_inv     (ssg_inv),
    .att_out     (att_out),
    .att_valid   (att_valid)
  );

endmodule

// File: hw/eg_envelope.sv
/*
  ADSR envelope with SSG alternate inversion; hold and attack-invert are not modeled.
  key_on and key_off only take effect together with sample_tick and never coincide.
*/
`timescale 1ns/100ps

module eg_envelope
  import eg_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic             sample_tick,
  input  logic             key_on,
  input  logic             key_off,
  input  eg_cfg_t          cfg,
  output logic [ATT_W-1:0] eg_att,
  output logic             ssg_inv
);

  eg_phase_e        phase;
  eg_phase_e        phase_nxt;
  logic [ATT_W-1:0] att_nxt;
  logic             inv_nxt;
  logic [ATT_W-1:0] sl_lvl;
  logic [ATT_W-1:0] ar_step;
  logic [ATT_W:0]   dec_sum;
  logic [ATT_W:0]   rel_sum;

  // Sustain target is sl * 32
  assign sl_lvl  = {cfg.sl, 5'b00000};
  assign ar_step = {6'd0, cfg.ar};

  // One extra bit so the step never wraps before the compare
  assign dec_sum = {1'b0, eg_att} + {7'd0, cfg.dr};
  assign rel_sum = {1'b0, eg_att} + {7'd0, cfg.rr};

  always_comb begin
    phase_nxt = phase;
    att_nxt   = eg_att;
    inv_nxt   = ssg_inv;

    if (sample_tick) begin
      if (key_on) begin
        phase_nxt = ph_attack;
        inv_nxt   = 1'b0;
      end else if (key_off) begin
        phase_nxt = ph_release;
      end else begin
        case (phase)
          ph_attack: begin
            if (eg_att <= ar_step) begin
              att_nxt   = '0;
              phase_nxt = ph_decay;
            end else begin
              att_nxt = eg_att - ar_step;
            end
          end
          ph_decay: begin
            // Clamp on the sustain level, even if it moved below us
            if (dec_sum >= {1'b0, sl_lvl}) begin
              att_nxt   = sl_lvl;
              phase_nxt = ph_sustain;
            end else begin
              att_nxt = dec_sum[ATT_W-1:0];
            end
          end
          ph_sustain: begin
            att_nxt = eg_att;
          end
          ph_release: begin
            if (rel_sum >= {1'b0, ATT_MAX}) begin
              att_nxt = ATT_MAX;
            end else begin
              att_nxt = rel_sum[ATT_W-1:0];
            end
          end
          default: begin
            phase_nxt = ph_release;
          end
        endcase

        // SSG alternate: crossing the midpoint flips polarity and restarts attack
        if (cfg.ssg_en && (phase == ph_decay || phase == ph_sustain) &&
            att_nxt >= SSG_MID) begin
          phase_nxt = ph_attack;
          inv_nxt   = ~ssg_inv;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      phase   <= ph_release;
      eg_att  <= ATT_MAX;
      ssg_inv <= 1'b0;
    end else begin
      phase   <= phase_nxt;
      eg_att  <= att_nxt;
      ssg_inv <= inv_nxt;
    end
  end

  a_key_excl: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(key_on && key_off)
  ) else $error("key_on and key_off asserted together");

  // Sustain sits on sl * 32 for as long as it lasts, so sl must not move meanwhile
  a_sustain_lvl: assert property (
    @(posedge clk) disable iff (!rst_n)
    (phase == ph_sustain) |-> (eg_att == {cfg.sl, 5'b00000})
  ) else $error("sustain attenuation %0h does not match sl", eg_att);

endmodule

// File: hw/eg_lfo_am.sv
/*
  AM phase of the LFO, advanced once every LFO_PRESCALE sample ticks.
  All updates happen on sample_tick only, including the clear while disabled.
*/
`timescale 1ns/100ps

module eg_lfo_am
  import eg_pkg::*;
#(
  parameter int LFO_PRESCALE = 4
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             sample_tick,
  input  logic             lfo_en,
  input  logic [2:0]       lfo_rate,
  output logic [LFO_W-1:0] lfo_mod
);

  // Counter wide enough for 0 .. LFO_PRESCALE-1
  localparam int PW = (LFO_PRESCALE > 1) ? $clog2(LFO_PRESCALE) : 1;

  logic [PW-1:0] presc;
  logic          presc_wrap;

  assign presc_wrap = (presc == PW'(LFO_PRESCALE - 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      presc   <= '0;
      lfo_mod <= '0;
    end else if (sample_tick) begin
      if (!lfo_en) begin
        presc   <= '0;
        lfo_mod <= '0;
      end else if (presc_wrap) begin
        presc   <= '0;
        // Phase wraps naturally at 128
        lfo_mod <= lfo_mod + {4'd0, lfo_rate};
      end else begin
        presc <= presc + 1'b1;
      end
    end
  end

  // The limiter relies on a phase that only moves on ticks
  a_phase_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    !sample_tick |=> $stable(lfo_mod)
  ) else $error("lfo_mod changed without sample_tick");

endmodule

// File: hw/eg_limiter.sv
/*
  Sums folded AM, total level and envelope and saturates at 0x3FF.
  Output is registered one cycle after the delayed tick and has no back-pressure.
*/
`timescale 1ns/100ps

module eg_limiter
  import eg_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic             sample_tick,
  input  eg_cfg_t          cfg,
  input  logic [LFO_W-1:0] lfo_mod,
  input  logic [ATT_W-1:0] eg_att,
  input  logic             ssg_inv,
  output logic [ATT_W-1:0] att_out,
  output logic             att_valid
);

  logic             tick_d;
  logic [5:0]       am_inverted;
  logic [8:0]       am_final;
  logic [ATT_W-1:0] eg_pream;
  logic [11:0]      sum_eg_tl;
  logic [11:0]      sum_eg_tl_am;
  logic [ATT_W-1:0] eg_limited;

  // Triangle fold of the LFO phase
  assign am_inverted = lfo_mod[6] ? ~lfo_mod[5:0] : lfo_mod[5:0];

  always_comb begin
    if (!cfg.amsen) begin
      am_final = 9'd0;
    end else begin
      case (cfg.ams)
        2'b01:   am_final = {5'd0, am_inverted[5:2]};
        2'b10:   am_final = {3'd0, am_inverted};
        2'b11:   am_final = {2'd0, am_inverted, 1'b0};
        default: am_final = 9'd0;
      endcase
    end
  end

  // Mirror about the midpoint while SSG inversion is active
  assign eg_pream = ssg_inv ? (SSG_MID - eg_att) : eg_att;

  assign sum_eg_tl    = {2'b00, cfg.tl, 3'b000} + {2'b00, eg_pream};
  assign sum_eg_tl_am = sum_eg_tl + {3'd0, am_final};

  assign eg_limited = (sum_eg_tl_am[11:10] == 2'b00) ? sum_eg_tl_am[ATT_W-1:0] : ATT_MAX;

  // Upstream registers settle one cycle after the tick
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tick_d    <= 1'b0;
      att_valid <= 1'b0;
      att_out   <= ATT_MAX;
    end else begin
      tick_d    <= sample_tick;
      att_valid <= tick_d;
      if (tick_d) begin
        att_out <= eg_limited;
      end
    end
  end

  a_valid_lat: assert property (
    @(posedge clk) disable iff (!rst_n)
    sample_tick |-> ##2 att_valid
  ) else $error("att_valid missing two cycles after sample_tick");

  a_valid_src: assert property (
    @(posedge clk) disable iff (!rst_n)
    att_valid |-> $past(sample_tick, 2)
  ) else $error("att_valid without a tick two cycles earlier");

  a_sum_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    sum_eg_tl <= 12'd2047
  ) else $error("total level plus envelope out of range: %0h", sum_eg_tl);

endmodule

// File: hw/eg_pkg.sv
/*
  Shared types and constants for the operator attenuation path.
  Attenuation is 10 bits where 0x3FF is silence. Rates are raw step sizes.
*/
package eg_pkg;

  // Datapath widths
  localparam int ATT_W = 10;
  localparam int LFO_W = 7;

  // Silence level and SSG mirror point
  localparam logic [ATT_W-1:0] ATT_MAX = 10'h3FF;
  localparam logic [ATT_W-1:0] SSG_MID = 10'h200;

  // Per-operator settings, 28 bits
  typedef struct packed {
    logic [6:0] tl;      // Total level, 0.75 dB per step after shift
    logic       amsen;   // AM enable
    logic [1:0] ams;     // AM sensitivity
    logic [3:0] ar;      // Attack step
    logic [3:0] dr;      // Decay step
    logic [3:0] rr;      // Release step
    logic [4:0] sl;      // Sustain level, scaled by 32
    logic       ssg_en;  // SSG alternate mode
  } eg_cfg_t;

  // Envelope phases
  typedef enum logic [1:0] {
    ph_attack  = 2'd0,
    ph_decay   = 2'd1,
    ph_sustain = 2'd2,
    ph_release = 2'd3
  } eg_phase_e;

endpackage

// File: project.f
hw/eg_pkg.sv
hw/eg_lfo_am.sv
hw/eg_envelope.sv
hw/eg_limiter.sv
hw/eg_atten_top.sv
tests/eg_atten_checker.sv
tests/tb_eg_atten.sv

// File: tests/eg_atten_checker.sv
/*
  Reference model of the attenuation path, stepped on every sampled tick.
  Assumes cfg stays stable from a tick until its valid. Counts are valid after reset.
*/
`timescale 1ns/100ps

module eg_atten_checker
  import eg_pkg::*;
#(
  parameter int LFO_PRESCALE = 4
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             sample_tick,
  input  logic             key_on,
  input  logic             key_off,
  input  eg_cfg_t          cfg,
  input  logic             lfo_en,
  input  logic [2:0]       lfo_rate,
  input  logic [ATT_W-1:0] att_out,
  input  logic             att_valid,
  input  logic             row_done,
  input  int               row_idx,
  input  logic [ATT_W-1:0] row_exp,
  input  logic             row_dc,
  input  logic             summary,
  output int               err_count,
  output int               chk_count
);

  // Model state
  eg_phase_e m_phase;
  int        m_att;
  logic      m_inv;
  int        m_presc;
  int        m_lfo;

  logic      tick_d1;
  logic      tick_d2;
  int        exp_att;
  int        last_att;
  int        row_err_base;
  int        rows_pass;
  int        rows_fail;

  // Folded AM, mirrored envelope and shifted total level, clipped to 10 bits
  function automatic int ref_att(input eg_cfg_t c, input int lfo, input int att, input logic inv);
    int am;
    int env;
    int sum;
    am = lfo % 64;
    if (lfo >= 64) am = 63 - am;
    if (!c.amsen) am = 0;
    else if (c.ams == 2'd0) am = 0;
    else if (c.ams == 2'd1) am = am / 4;
    else if (c.ams == 2'd3) am = am * 2;
    env = inv ? ((512 - att) & 1023) : att;
    sum = int'(c.tl) * 8 + env + am;
    return (sum > 1023) ? 1023 : sum;
  endfunction

  task automatic step_env();
    eg_phase_e prev;
    prev = m_phase;
    if (key_on) begin
      m_phase = ph_attack;
      m_inv   = 1'b0;
    end else if (key_off) begin
      m_phase = ph_release;
    end else begin
      case (m_phase)
        ph_attack: begin
          m_att = m_att - int'(cfg.ar);
          if (m_att <= 0) begin
            m_att   = 0;
            m_phase = ph_decay;
          end
        end
        ph_decay: begin
          m_att = m_att + int'(cfg.dr);
          if (m_att >= int'(cfg.sl) * 32) begin
            m_att   = int'(cfg.sl) * 32;
            m_phase = ph_sustain;
          end
        end
        ph_sustain: begin
          // Level holds until key off or an SSG flip
        end
        ph_release: begin
          m_att = m_att + int'(cfg.rr);
          if (m_att > 1023) m_att = 1023;
        end
      endcase
      if (cfg.ssg_en && (prev == ph_decay || prev == ph_sustain) && m_att >= 512) begin
        m_phase = ph_attack;
        m_inv   = !m_inv;
      end
    end
  endtask

  task automatic step_lfo();
    if (!lfo_en) begin
      m_presc = 0;
      m_lfo   = 0;
    end else if (m_presc == LFO_PRESCALE - 1) begin
      m_presc = 0;
      m_lfo   = (m_lfo + int'(lfo_rate)) % 128;
    end else begin
      m_presc = m_presc + 1;
    end
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      m_phase      = ph_release;
      m_att        = 1023;
      m_inv        = 1'b0;
      m_presc      = 0;
      m_lfo        = 0;
      tick_d1      = 1'b0;
      tick_d2      = 1'b0;
      exp_att      = 1023;
      last_att     = 1023;
      row_err_base = 0;
      rows_pass    = 0;
      rows_fail    = 0;
      err_count    = 0;
      chk_count    = 0;
    end else begin
      if (att_valid) begin
        if (!tick_d2) begin
          $display("att_valid arrived without a sample_tick two cycles before");
          err_count = err_count + 1;
        end else begin
          chk_count = chk_count + 1;
          if (att_out !== 10'(exp_att)) begin
            $display("Mismatch att_out: got 0x%h, expected 0x%h", att_out, 10'(exp_att));
            err_count = err_count + 1;
          end
        end
        last_att = int'(att_out);
      end else if (tick_d2) begin
        $display("No att_valid two cycles after a sample_tick");
        err_count = err_count + 1;
      end

      if (row_done) begin
        if (!row_dc && last_att != int'(row_exp)) begin
          $display("Mismatch att_out at end of row %0d: got 0x%h, expected 0x%h",
                   row_idx, 10'(last_att), row_exp);
          err_count = err_count + 1;
        end
        if (err_count == row_err_base) begin
          rows_pass = rows_pass + 1;
          $display("Row %0d passed, final att_out 0x%h", row_idx, 10'(last_att));
        end else begin
          rows_fail = rows_fail + 1;
          $display("Row %0d failed with %0d errors", row_idx, err_count - row_err_base);
        end
        row_err_base = err_count;
      end

      if (summary) begin
        $display("Rows passed %0d, rows failed %0d, outputs checked %0d, errors %0d",
                 rows_pass, rows_fail, chk_count, err_count);
      end

      // Limiter samples one cycle after the tick, before this edge's update
      if (tick_d1) exp_att = ref_att(cfg, m_lfo, m_att, m_inv);
      tick_d2 = tick_d1;
      tick_d1 = sample_tick;
      if (sample_tick) begin
        step_env();
        step_lfo();
      end
    end
  end

endmodule

// File: tests/tb_eg_atten.sv
/*
  Testbench for the attenuation path, one tick every 4 clocks from a stimulus table.
  Expected final values assume LFO_PRESCALE of 4.
*/
`timescale 1ns/100ps

module tb_eg_atten
  import eg_pkg::*;
();

  localparam int         LFO_PRESCALE = 4;
  localparam int         TICK_TIMEOUT = 16;
  localparam logic [1:0] KEY_NONE     = 2'd0;
  localparam logic [1:0] KEY_ON       = 2'd1;
  localparam logic [1:0] KEY_OFF      = 2'd2;

  typedef struct packed {
    eg_cfg_t          cfg;
    logic             lfo_en;
    logic [2:0]       lfo_rate;
    logic [1:0]       key;      // Applied on the first tick of the row
    logic [9:0]       n_ticks;
    logic [ATT_W-1:0] exp_att;
    logic             dc;       // Final value not checked
  } row_t;

  logic             clk;
  logic             rst_n;
  logic             sample_tick;
  logic             key_on;
  logic             key_off;
  eg_cfg_t          cfg;
  logic             lfo_en;
  logic [2:0]       lfo_rate;
  logic [ATT_W-1:0] att_out;
  logic             att_valid;
  logic             row_done;
  int               row_idx;
  logic [ATT_W-1:0] row_exp;
  logic             row_dc;
  logic             summary;
  int               err_count;
  int               chk_count;
  row_t             rows[$];

  eg_atten_top #(
    .LFO_PRESCALE (LFO_PRESCALE)
  ) u_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .sample_tick (sample_tick),
    .key_on      (key_on),
    .key_off     (key_off),
    .cfg         (cfg),
    .lfo_en      (lfo_en),
    .lfo_rate    (lfo_rate),
    .att_out     (att_out),
    .att_valid   (att_valid)
  );

  eg_atten_checker #(
    .LFO_PRESCALE (LFO_PRESCALE)
  ) u_chk (
    .clk         (clk),
    .rst_n       (rst_n),
    .sample_tick (sample_tick),
    .key_on      (key_on),
    .key_off     (key_off),
    .cfg         (cfg),
    .lfo_en      (lfo_en),
    .lfo_rate    (lfo_rate),
    .att_out     (att_out),
    .att_valid   (att_valid),
    .row_done    (row_done),
    .row_idx     (row_idx),
    .row_exp     (row_exp),
    .row_dc      (row_dc),
    .summary     (summary),
    .err_count   (err_count),
    .chk_count   (chk_count)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic eg_cfg_t make_cfg(input int tl, input int amsen, input int ams,
                                       input int ar, input int dr, input int rr,
                                       input int sl, input int ssg);
    eg_cfg_t c;
    c.tl     = 7'(tl);
    c.amsen  = 1'(amsen);
    c.ams    = 2'(ams);
    c.ar     = 4'(ar);
    c.dr     = 4'(dr);
    c.rr     = 4'(rr);
    c.sl     = 5'(sl);
    c.ssg_en = 1'(ssg);
    return c;
  endfunction

  task automatic add_row(input eg_cfg_t c, input logic en, input int rate, input logic [1:0] key,
                         input int n, input int exp_val, input logic dc);
    row_t r;
    r.cfg      = c;
    r.lfo_en   = en;
    r.lfo_rate = 3'(rate);
    r.key      = key;
    r.n_ticks  = 10'(n);
    r.exp_att  = 10'(exp_val);
    r.dc       = dc;
    rows.push_back(r);
  endtask

  task automatic build_table();
    int a;
    // Idle after reset, release stays at silence
    add_row(make_cfg(0, 0, 0, 0, 0, 4, 0, 0), 1'b0, 0, KEY_NONE, 6, 'h3FF, 1'b0);
    // Attack to 0 in 69 ticks, decay by 8 to 256, then hold
    add_row(make_cfg(0, 0, 0, 15, 8, 15, 8, 0), 1'b0, 0, KEY_ON, 110, 'h100, 1'b0);
    add_row(make_cfg(0, 0, 0, 15, 8, 15, 8, 0), 1'b0, 0, KEY_OFF, 20, 'h21D, 1'b0);
    add_row(make_cfg(0, 0, 0, 15, 8, 15, 8, 0), 1'b0, 0, KEY_NONE, 40, 'h3FF, 1'b0);
    // Park the envelope at 0 for the AM rows
    add_row(make_cfg(0, 0, 0, 15, 0, 0, 0, 0), 1'b0, 0, KEY_ON, 80, 'h000, 1'b0);
    for (a = 0; a < 8; a++) begin
      add_row(make_cfg(0, (a < 4) ? 1 : 0, a % 4, 15, 0, 0, 0, 0), 1'b1,
              int'($urandom % 8), KEY_NONE, 40, 0, 1'b1);
    end
    // LFO cleared, then 10 steps of 7 give phase 70, folded to 57, doubled
    add_row(make_cfg(0, 1, 3, 15, 0, 0, 0, 0), 1'b0, 0, KEY_NONE, 2, 'h000, 1'b0);
    add_row(make_cfg(0, 1, 3, 15, 0, 0, 0, 0), 1'b1, 7, KEY_NONE, 40, 'h072, 1'b0);
    // Saturation around 1016 + envelope
    add_row(make_cfg(127, 0, 0, 15, 0, 0, 0, 0), 1'b0, 0, KEY_NONE, 4, 'h3F8, 1'b0);
    add_row(make_cfg(127, 0, 0, 15, 0, 7, 0, 0), 1'b0, 0, KEY_OFF, 2, 'h3FF, 1'b0);
    add_row(make_cfg(127, 0, 0, 15, 0, 1, 0, 0), 1'b0, 0, KEY_NONE, 1, 'h3FF, 1'b0);
    add_row(make_cfg(127, 0, 0, 15, 0, 15, 0, 0), 1'b0, 0, KEY_NONE, 20, 'h3FF, 1'b0);
    // SSG: attack from 308, decay by 1 to 512 flips, then mirrored attack
    add_row(make_cfg(0, 0, 0, 15, 1, 0, 31, 1), 1'b0, 0, KEY_ON, 534, 'h000, 1'b0);
    add_row(make_cfg(0, 0, 0, 15, 1, 0, 31, 1), 1'b0, 0, KEY_NONE, 6, 'h05A, 1'b0);
  endtask

  // Called just after a rising edge, returns just after the edge that shows att_valid
  task automatic issue_tick(input logic [1:0] key, output bit ok);
    int waited;
    sample_tick = 1'b1;
    key_on      = (key == KEY_ON);
    key_off     = (key == KEY_OFF);
    @(posedge clk);
    #1;
    sample_tick = 1'b0;
    key_on      = 1'b0;
    key_off     = 1'b0;
    waited      = 0;
    ok          = 1'b0;
    while (!ok && waited < TICK_TIMEOUT) begin
      @(posedge clk);
      #1;
      waited = waited + 1;
      if (att_valid) ok = 1'b1;
    end
  endtask

  task automatic apply_row(input int idx, input row_t r, output bit ok);
    int t;
    cfg      = r.cfg;
    lfo_en   = r.lfo_en;
    lfo_rate = r.lfo_rate;
    ok       = 1'b1;
    for (t = 0; t < int'(r.n_ticks) && ok; t++) begin
      issue_tick((t == 0) ? r.key : KEY_NONE, ok);
      if (ok) begin
        if (t == int'(r.n_ticks) - 1) begin
          row_idx  = idx;
          row_exp  = r.exp_att;
          row_dc   = r.dc;
          row_done = 1'b1;
        end
        @(posedge clk);
        #1;
        row_done = 1'b0;
        @(posedge clk);
        #1;
      end
    end
  endtask

  initial begin
    bit ok;
    int i;
    rst_n       = 1'b0;
    sample_tick = 1'b0;
    key_on      = 1'b0;
    key_off     = 1'b0;
    cfg         = '0;
    lfo_en      = 1'b0;
    lfo_rate    = 3'd0;
    row_done    = 1'b0;
    row_idx     = 0;
    row_exp     = '0;
    row_dc      = 1'b0;
    summary     = 1'b0;
    void'($urandom(9));
    build_table();
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    ok = 1'b1;
    i  = 0;
    while (i < rows.size() && ok) begin
      apply_row(i, rows[i], ok);
      if (ok) i = i + 1;
    end
    if (!ok) begin
      $display("Timeout in row %0d: no att_valid within %0d cycles of a tick", i, TICK_TIMEOUT);
      $display("TESTBENCH FAILED");
    end else begin
      summary = 1'b1;
      @(posedge clk);
      #1;
      summary = 1'b0;
      if (err_count == 0 && chk_count > 0) begin
        $display("TESTBENCH PASSED");
      end else begin
        $display("TESTBENCH FAILED");
      end
    end
    $finish;
  end

endmodule
